/* verilog/exu_settings.svh */
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// data and address width
`define EXU_XLEN 32

// global history bits handed over by the predictor
`define EXU_HISLEN 8

// trap bus, passed through untouched
`define EXU_TRAP_LEN 4

// predictor accuracy counters
`define EXU_CNT_LEN 16

`endif

/* verilog/exu_isa_pkg.sv */
package exu_isa_pkg;

  // execute class, set by decode
  typedef enum logic [3:0] {
    EXC_NONE   = 4'd0,
    EXC_OPREG  = 4'd1,
    EXC_OPIMM  = 4'd2,
    EXC_LOAD   = 4'd3,
    EXC_STORE  = 4'd4,
    EXC_LUI    = 4'd5,
    EXC_AUIPC  = 4'd6,
    EXC_JAL    = 4'd7,
    EXC_JALR   = 4'd8,
    EXC_BRANCH = 4'd9,
    EXC_EBREAK = 4'd10    // highest legal code
  } exc_op_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  // branch compare, funct3 order without the gaps
  typedef enum logic [2:0] {
    BR_EQ  = 3'd0,
    BR_NE  = 3'd1,
    BR_LT  = 3'd2,
    BR_GE  = 3'd3,
    BR_LTU = 3'd4,
    BR_GEU = 3'd5
  } br_cond_e;

  // jump type as the predictor sees it
  typedef enum logic [1:0] {
    JT_NONE   = 2'd0,
    JT_JAL    = 2'd1,
    JT_JALR   = 2'd2,
    JT_BRANCH = 2'd3
  } jump_type_e;

endpackage

/* verilog/bpu_pkg.sv */
`include "exu_settings.svh"

package bpu_pkg;
  import exu_isa_pkg::*;

  // guess made at fetch, travels with the instruction
  typedef struct packed {
    logic                   pred_taken;
    logic                   which_pdt;   // predictor that made the guess
    logic [`EXU_HISLEN-1:0] history;
  } pred_info_t;

  // training record back to the predictor
  typedef struct packed {
    logic                   valid;
    logic                   taken;
    logic                   correct;
    logic [`EXU_XLEN-1:0]   pc;
    jump_type_e             jump_type;
    logic                   which_pdt;
    logic [`EXU_HISLEN-1:0] history;
  } bpu_update_t;

endpackage

/* verilog/exu_if.sv */
`timescale 1ns/10ps
`include "exu_settings.svh"

// decoded instruction entering execute
interface exu_issue_if
  import exu_isa_pkg::*, bpu_pkg::*;
(
  input logic clk_i
);

  logic                     valid;
  logic [`EXU_XLEN-1:0]     pc;
  logic [`EXU_XLEN-1:0]     rs1;
  logic [`EXU_XLEN-1:0]     rs2;
  logic [`EXU_XLEN-1:0]     imm;
  logic [4:0]               rd;
  exc_op_e                  exc_op;
  alu_op_e                  alu_op;
  br_cond_e                 br_cond;
  pred_info_t               pred;
  logic [`EXU_TRAP_LEN-1:0] trap;

  modport source (output valid, pc, rs1, rs2, imm, rd, exc_op, alu_op, br_cond, pred, trap);

  // retire also reads the record through this one
  modport alu (input clk_i, valid, pc, rs1, rs2, imm, rd, exc_op, alu_op, pred, trap);

  modport branch (input clk_i, valid, pc, rs1, rs2, imm, exc_op, br_cond, pred);

endinterface

// resolved branch outcome
interface branch_res_if
  import exu_isa_pkg::*;
();

  logic                 is_jump;
  logic                 taken;
  logic [`EXU_XLEN-1:0] target;
  logic                 mispredict;
  jump_type_e           jump_type;

  modport source (output is_jump, taken, target, mispredict, jump_type);
  modport sink   (input is_jump, taken, target, mispredict, jump_type);

endinterface

/* verilog/alu_core.sv */
`timescale 1ns/10ps
`include "exu_settings.svh"

module alu_core
  import exu_isa_pkg::*;
(
  exu_issue_if.alu             issue_i,
  output logic [`EXU_XLEN-1:0] result_o
);

  logic [`EXU_XLEN-1:0] op_a;
  logic [`EXU_XLEN-1:0] op_b;
  logic [`EXU_XLEN-1:0] imm_upper;
  logic [4:0]           shamt;
  alu_op_e              op;

  assign imm_upper = {issue_i.imm[`EXU_XLEN-1:12], 12'b0};  // lui / auipc
  assign shamt     = op_b[4:0];

  // operand a
  always_comb begin
    case (issue_i.exc_op)
      EXC_OPREG, EXC_OPIMM, EXC_LOAD, EXC_STORE: op_a = issue_i.rs1;
      EXC_JAL, EXC_JALR, EXC_AUIPC:              op_a = issue_i.pc;
      default:                                   op_a = '0;  // lui, idle classes
    endcase
  end

  // operand b
  always_comb begin
    case (issue_i.exc_op)
      EXC_OPREG:                      op_b = issue_i.rs2;
      EXC_OPIMM, EXC_LOAD, EXC_STORE: op_b = issue_i.imm;
      EXC_JAL, EXC_JALR:              op_b = `EXU_XLEN'd4;    // link address
      EXC_LUI, EXC_AUIPC:             op_b = imm_upper;
      default:                        op_b = '0;
    endcase
  end

  // only the two arithmetic classes pick their own op, the rest just add
  assign op = (issue_i.exc_op == EXC_OPREG || issue_i.exc_op == EXC_OPIMM) ?
              issue_i.alu_op : ALU_ADD;

  always_comb begin
    case (op)
      ALU_ADD:  result_o = op_a + op_b;
      ALU_SUB:  result_o = op_a - op_b;
      ALU_SLL:  result_o = op_a << shamt;
      ALU_SLT:  result_o = {{(`EXU_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: result_o = {{(`EXU_XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:  result_o = op_a ^ op_b;
      ALU_SRL:  result_o = op_a >> shamt;
      ALU_SRA:  result_o = $unsigned($signed(op_a) >>> shamt);  // keeps the sign
      ALU_OR:   result_o = op_a | op_b;
      ALU_AND:  result_o = op_a & op_b;
      default:  result_o = '0;
    endcase
  end

  // decode must never hand over a reserved class code
  a_exc_op_defined: assert property (@(posedge issue_i.clk_i)
    issue_i.valid |-> issue_i.exc_op <= EXC_EBREAK)
    else $error("alu_core: undefined exc_op %0d", issue_i.exc_op);

endmodule

/* verilog/branch_resolver.sv */
`timescale 1ns/10ps
`include "exu_settings.svh"

module branch_resolver
  import exu_isa_pkg::*, bpu_pkg::*;
(
  exu_issue_if.branch  issue_i,
  branch_res_if.source res_o
);

  logic                 is_branch;
  logic                 is_jal;
  logic                 is_jalr;
  logic                 cond_met;
  logic [`EXU_XLEN-1:0] jalr_sum;
  pred_info_t           pred;

  assign is_branch = (issue_i.exc_op == EXC_BRANCH);
  assign is_jal    = (issue_i.exc_op == EXC_JAL);
  assign is_jalr   = (issue_i.exc_op == EXC_JALR);
  assign pred      = issue_i.pred;

  // compare rs1 against rs2
  always_comb begin
    case (issue_i.br_cond)
      BR_EQ:   cond_met = (issue_i.rs1 == issue_i.rs2);
      BR_NE:   cond_met = (issue_i.rs1 != issue_i.rs2);
      BR_LT:   cond_met = ($signed(issue_i.rs1) < $signed(issue_i.rs2));
      BR_GE:   cond_met = ($signed(issue_i.rs1) >= $signed(issue_i.rs2));
      BR_LTU:  cond_met = (issue_i.rs1 < issue_i.rs2);
      BR_GEU:  cond_met = (issue_i.rs1 >= issue_i.rs2);
      default: cond_met = 1'b0;
    endcase
  end

  assign res_o.is_jump = is_branch | is_jal | is_jalr;
  assign res_o.taken   = (is_branch & cond_met) | is_jal | is_jalr;  // jumps always go

  // jalr drops bit 0 of the sum
  assign jalr_sum     = issue_i.rs1 + issue_i.imm;
  assign res_o.target = is_jalr ? {jalr_sum[`EXU_XLEN-1:1], 1'b0} : issue_i.pc + issue_i.imm;

  always_comb begin
    case (issue_i.exc_op)
      EXC_JAL:    res_o.jump_type = JT_JAL;
      EXC_JALR:   res_o.jump_type = JT_JALR;
      EXC_BRANCH: res_o.jump_type = JT_BRANCH;
      default:    res_o.jump_type = JT_NONE;
    endcase
  end

  // a guessed-taken non-jump is wrong too, fetch already left the line
  assign res_o.mispredict = res_o.is_jump ? (res_o.taken != pred.pred_taken) :
                            pred.pred_taken;

  // branch and jal offsets come aligned from decode
  a_target_aligned: assert property (@(posedge issue_i.clk_i)
    issue_i.valid && res_o.taken |-> res_o.target[0] == 1'b0)
    else $error("branch_resolver: odd target %h", res_o.target);

endmodule

/* verilog/exu_retire.sv */
`timescale 1ns/10ps
`include "exu_settings.svh"

module exu_retire
  import exu_isa_pkg::*, bpu_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     stall_i,       // memory stall, freezes ex/mem
  exu_issue_if.alu                 issue_i,
  input  logic [`EXU_XLEN-1:0]     alu_result_i,
  branch_res_if.sink               br_i,
  output logic                     valid_o,
  output logic [`EXU_XLEN-1:0]     pc_o,
  output logic [4:0]               rd_o,
  output logic [`EXU_XLEN-1:0]     result_o,
  output logic [`EXU_TRAP_LEN-1:0] trap_o,
  output logic                     redirect_valid_o,
  output logic [`EXU_XLEN-1:0]     redirect_pc_o,
  output logic                     flush_o,
  output bpu_update_t              bpu_o,
  output logic [`EXU_CNT_LEN-1:0]  bpu_total_o,
  output logic [`EXU_CNT_LEN-1:0]  bpu_correct_o
);

  logic                   jump_acc;     // jump leaving ex this cycle
  logic                   redirect;
  logic [`EXU_XLEN-1:0]   seq_pc;
  logic                   bpu_valid_q;
  logic                   bpu_taken_q;
  logic                   bpu_correct_q;
  jump_type_e             bpu_type_q;
  logic                   bpu_which_q;
  logic [`EXU_HISLEN-1:0] bpu_hist_q;

  assign jump_acc = issue_i.valid & br_i.is_jump & ~stall_i;
  assign redirect = issue_i.valid & br_i.mispredict;
  assign seq_pc   = issue_i.pc + `EXU_XLEN'd4;

  // strobes, trap and counters
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o          <= 1'b0;
      redirect_valid_o <= 1'b0;
      flush_o          <= 1'b0;
      bpu_valid_q      <= 1'b0;
      trap_o           <= '0;
      bpu_total_o      <= '0;
      bpu_correct_o    <= '0;
    end else if (!stall_i) begin
      valid_o          <= issue_i.valid;
      redirect_valid_o <= redirect;
      flush_o          <= redirect;    // younger stages drop their work
      bpu_valid_q      <= issue_i.valid & br_i.is_jump;
      trap_o           <= issue_i.valid ? issue_i.trap : '0;
      if (jump_acc) begin
        bpu_total_o <= bpu_total_o + `EXU_CNT_LEN'd1;
        if (!br_i.mispredict) begin
          bpu_correct_o <= bpu_correct_o + `EXU_CNT_LEN'd1;
        end
      end
    end
  end

  // ex/mem payload
  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      pc_o          <= issue_i.pc;
      rd_o          <= issue_i.rd;
      result_o      <= alu_result_i;
      redirect_pc_o <= br_i.taken ? br_i.target : seq_pc;
      bpu_taken_q   <= br_i.taken;
      bpu_correct_q <= ~br_i.mispredict;
      bpu_type_q    <= br_i.jump_type;
      bpu_which_q   <= issue_i.pred.which_pdt;
      bpu_hist_q    <= issue_i.pred.history;
    end
  end

  assign bpu_o = '{valid: bpu_valid_q, taken: bpu_taken_q, correct: bpu_correct_q,
                   pc: pc_o, jump_type: bpu_type_q, which_pdt: bpu_which_q,
                   history: bpu_hist_q};

  a_redirect_has_inst: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    redirect_valid_o |-> valid_o)
    else $error("exu_retire: redirect without an instruction");

  // correct jumps are a subset of all jumps
  a_cnt_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bpu_correct_o <= bpu_total_o)
    else $error("exu_retire: correct count %0d above total %0d", bpu_correct_o, bpu_total_o);

endmodule

/* verilog/exu_top.sv */
`timescale 1ns/10ps
`include "exu_settings.svh"

module exu_top
  import exu_isa_pkg::*, bpu_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     stall_i,
  input  logic                     valid_i,
  input  logic [`EXU_XLEN-1:0]     pc_i,
  input  logic [`EXU_XLEN-1:0]     rs1_i,
  input  logic [`EXU_XLEN-1:0]     rs2_i,
  input  logic [`EXU_XLEN-1:0]     imm_i,
  input  logic [4:0]               rd_i,
  input  exc_op_e                  exc_op_i,
  input  alu_op_e                  alu_op_i,
  input  br_cond_e                 br_cond_i,
  input  logic                     pred_taken_i,
  input  logic                     which_pdt_i,
  input  logic [`EXU_HISLEN-1:0]   history_i,
  input  logic [`EXU_TRAP_LEN-1:0] trap_i,
  output logic                     valid_o,
  output logic [`EXU_XLEN-1:0]     pc_o,
  output logic [4:0]               rd_o,
  output logic [`EXU_XLEN-1:0]     result_o,
  output logic [`EXU_TRAP_LEN-1:0] trap_o,
  output logic                     redirect_valid_o,
  output logic [`EXU_XLEN-1:0]     redirect_pc_o,
  output logic                     flush_o,
  output logic                     bpu_valid_o,
  output logic                     bpu_taken_o,
  output logic                     bpu_correct_o,
  output logic [`EXU_XLEN-1:0]     bpu_pc_o,
  output jump_type_e               bpu_jump_type_o,
  output logic                     bpu_which_pdt_o,
  output logic [`EXU_HISLEN-1:0]   bpu_history_o,
  output logic [`EXU_CNT_LEN-1:0]  cnt_total_o,
  output logic [`EXU_CNT_LEN-1:0]  cnt_correct_o
);

  exu_issue_if  issue (.clk_i(clk_i));
  branch_res_if br_res ();

  logic [`EXU_XLEN-1:0] alu_result;
  bpu_update_t          bpu_upd;

  // issue record from the id/ex ports
  assign issue.valid   = valid_i;
  assign issue.pc      = pc_i;
  assign issue.rs1     = rs1_i;
  assign issue.rs2     = rs2_i;
  assign issue.imm     = imm_i;
  assign issue.rd      = rd_i;
  assign issue.exc_op  = exc_op_i;
  assign issue.alu_op  = alu_op_i;
  assign issue.br_cond = br_cond_i;
  assign issue.trap    = trap_i;
  assign issue.pred    = '{pred_taken: pred_taken_i, which_pdt: which_pdt_i,
                           history: history_i};

  alu_core u_alu (
    .issue_i  (issue.alu),
    .result_o (alu_result)
  );

  branch_resolver u_branch (
    .issue_i (issue.branch),
    .res_o   (br_res.source)
  );

  exu_retire u_retire (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .stall_i          (stall_i),
    .issue_i          (issue.alu),
    .alu_result_i     (alu_result),
    .br_i             (br_res.sink),
    .valid_o          (valid_o),
    .pc_o             (pc_o),
    .rd_o             (rd_o),
    .result_o         (result_o),
    .trap_o           (trap_o),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o),
    .flush_o          (flush_o),
    .bpu_o            (bpu_upd),
    .bpu_total_o      (cnt_total_o),
    .bpu_correct_o    (cnt_correct_o)
  );

  // predictor update, flat at the boundary
  assign bpu_valid_o     = bpu_upd.valid;
  assign bpu_taken_o     = bpu_upd.taken;
  assign bpu_correct_o   = bpu_upd.correct;
  assign bpu_pc_o        = bpu_upd.pc;
  assign bpu_jump_type_o = bpu_upd.jump_type;
  assign bpu_which_pdt_o = bpu_upd.which_pdt;
  assign bpu_history_o   = bpu_upd.history;

endmodule

/* testbench/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #(PERIOD_NS / 2) clk_o = ~clk_o;  // even duty cycle

endmodule

/* testbench/tb_exu.sv */
`timescale 1ns/10ps
`include "exu_settings.svh"

module tb_exu
  import exu_isa_pkg::*;
();

  localparam int XW      = `EXU_XLEN;
  localparam int CLK_NS  = 100;
  localparam int N_ISSUE = 108;                // instructions over all tests

  logic                     clk_i, rst_n_i, stall_i, valid_i;
  logic [XW-1:0]            pc_i, rs1_i, rs2_i, imm_i;
  logic [4:0]               rd_i;
  exc_op_e                  exc_op_i;
  alu_op_e                  alu_op_i;
  br_cond_e                 br_cond_i;
  logic                     pred_taken_i, which_pdt_i;
  logic [`EXU_HISLEN-1:0]   history_i;
  logic [`EXU_TRAP_LEN-1:0] trap_i;
  logic                     valid_o, redirect_valid_o, flush_o;
  logic [XW-1:0]            pc_o, result_o, redirect_pc_o, bpu_pc_o;
  logic [4:0]               rd_o;
  logic [`EXU_TRAP_LEN-1:0] trap_o;
  logic                     bpu_valid_o, bpu_taken_o, bpu_correct_o, bpu_which_pdt_o;
  jump_type_e               bpu_jump_type_o;
  logic [`EXU_HISLEN-1:0]   bpu_history_o;
  logic [`EXU_CNT_LEN-1:0]  cnt_total_o, cnt_correct_o;

  // expected ex/mem record
  logic                     e_valid, e_rv, e_bv, e_bt, e_bc, e_wp;
  logic [XW-1:0]            e_pc, e_result, e_rpc;
  logic [4:0]               e_rd;
  logic [`EXU_TRAP_LEN-1:0] e_trap;
  jump_type_e               e_jt;
  logic [`EXU_HISLEN-1:0]   e_hist;
  logic [`EXU_CNT_LEN-1:0]  e_tot, e_cor;

  int seed  = 32'h28f2;
  int n_err = 0;
  int n_chk = 0;

  tb_clk_gen #(.PERIOD_NS(CLK_NS)) u_clk (.clk_o(clk_i));

  exu_top u_dut (.*);

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  function automatic int unsigned pick(int unsigned n);
    logic [31:0] r;
    r = $random(seed);
    return r % n;
  endfunction

  // result as the rv32i spec defines it per class
  function automatic logic [31:0] alu_ref(exc_op_e c, alu_op_e op, logic [31:0] pc,
                                          logic [31:0] a, logic [31:0] r2, logic [31:0] im);
    logic [31:0] b;
    b = (c == EXC_OPREG) ? r2 : im;
    case (c)
      EXC_LOAD, EXC_STORE: return a + im;
      EXC_LUI:             return {im[31:12], 12'h000};
      EXC_AUIPC:           return pc + {im[31:12], 12'h000};
      EXC_JAL, EXC_JALR:   return pc + 32'd4;   // link
      EXC_OPREG, EXC_OPIMM: begin
        case (op)
          ALU_ADD:  return a + b;
          ALU_SUB:  return a - b;
          ALU_SLL:  return a << b[4:0];
          ALU_SLT:  return 32'($signed(a) < $signed(b));
          ALU_SLTU: return 32'(a < b);
          ALU_XOR:  return a ^ b;
          ALU_SRL:  return a >> b[4:0];
          ALU_SRA:  return 32'($signed(a) >>> b[4:0]);
          ALU_OR:   return a | b;
          default:  return a & b;
        endcase
      end
      default: return 32'h0;
    endcase
  endfunction

  function automatic logic taken_ref(exc_op_e c, br_cond_e bc, logic [31:0] a, logic [31:0] b);
    if (c == EXC_JAL || c == EXC_JALR) return 1'b1;
    if (c != EXC_BRANCH) return 1'b0;
    case (bc)
      BR_EQ:   return a == b;
      BR_NE:   return a != b;
      BR_LT:   return $signed(a) < $signed(b);
      BR_GE:   return $signed(a) >= $signed(b);
      BR_LTU:  return a < b;
      BR_GEU:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // one expected record per accepted cycle
  always @(posedge clk_i) begin : ref_model
    logic        tk;
    logic        mis;
    logic [31:0] tgt;
    if (!rst_n_i) begin
      e_valid = 1'b0;
      e_rv    = 1'b0;
      e_bv    = 1'b0;
      e_tot   = '0;
      e_cor   = '0;
    end else if (!stall_i) begin
      case (exc_op_i)
        EXC_JAL:    e_jt = JT_JAL;
        EXC_JALR:   e_jt = JT_JALR;
        EXC_BRANCH: e_jt = JT_BRANCH;
        default:    e_jt = JT_NONE;
      endcase
      tk  = taken_ref(exc_op_i, br_cond_i, rs1_i, rs2_i);
      mis = (e_jt != JT_NONE) ? (tk != pred_taken_i) : pred_taken_i;
      tgt = (exc_op_i == EXC_JALR) ? ((rs1_i + imm_i) & ~32'h1) : pc_i + imm_i;
      e_valid  = valid_i;
      e_rv     = valid_i & mis;
      e_bv     = valid_i & (e_jt != JT_NONE);
      e_pc     = pc_i;
      e_rd     = rd_i;
      e_result = alu_ref(exc_op_i, alu_op_i, pc_i, rs1_i, rs2_i, imm_i);
      e_trap   = trap_i;
      e_rpc    = tk ? tgt : pc_i + 32'd4;
      e_bt     = tk;
      e_bc     = ~mis;
      e_wp     = which_pdt_i;
      e_hist   = history_i;
      if (e_bv) begin
        e_tot = e_tot + `EXU_CNT_LEN'd1;
        if (!mis) e_cor = e_cor + `EXU_CNT_LEN'd1;
      end
    end
  end

  task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
    n_chk++;
    if (got !== exp) begin
      n_err++;
      $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_out();
    compare("valid_o", 32'(valid_o), 32'(e_valid));
    compare("redirect_valid_o", 32'(redirect_valid_o), 32'(e_rv));
    compare("flush_o", 32'(flush_o), 32'(e_rv));
    compare("bpu_valid_o", 32'(bpu_valid_o), 32'(e_bv));
    compare("cnt_total_o", 32'(cnt_total_o), 32'(e_tot));
    compare("cnt_correct_o", 32'(cnt_correct_o), 32'(e_cor));
    if (e_valid) begin
      compare("pc_o", pc_o, e_pc);
      compare("rd_o", 32'(rd_o), 32'(e_rd));
      compare("result_o", result_o, e_result);
      compare("trap_o", 32'(trap_o), 32'(e_trap));
      compare("redirect_pc_o", redirect_pc_o, e_rpc);
    end
    if (e_bv) begin                                  // predictor fields only for jumps
      compare("bpu_taken_o", 32'(bpu_taken_o), 32'(e_bt));
      compare("bpu_correct_o", 32'(bpu_correct_o), 32'(e_bc));
      compare("bpu_pc_o", bpu_pc_o, e_pc);
      compare("bpu_jump_type_o", 32'(bpu_jump_type_o), 32'(e_jt));
      compare("bpu_which_pdt_o", 32'(bpu_which_pdt_o), 32'(e_wp));
      compare("bpu_history_o", 32'(bpu_history_o), 32'(e_hist));
    end
  endtask

  // hold gives the stalled cycles before the instruction is taken
  task automatic issue(exc_op_e c, alu_op_e op, br_cond_e bc, logic [31:0] pc, logic [31:0] a,
                       logic [31:0] b, logic [31:0] im, logic pt, int hold = 0);
    logic [31:0] r;
    r = rnd();
    @(posedge clk_i);
    valid_i      <= 1'b1;
    exc_op_i     <= c;
    alu_op_i     <= op;
    br_cond_i    <= bc;
    pc_i         <= pc;
    rs1_i        <= a;
    rs2_i        <= b;
    imm_i        <= im;
    pred_taken_i <= pt;
    rd_i         <= r[4:0];
    which_pdt_i  <= r[5];
    history_i    <= `EXU_HISLEN'(r >> 6);
    trap_i       <= `EXU_TRAP_LEN'(r >> 20);
    stall_i      <= (hold > 0);
    @(negedge clk_i);
    check_out();
    for (int i = 0; i < hold; i++) begin
      @(posedge clk_i);
      stall_i <= (i < hold - 1);                     // inputs stay as they are
      @(negedge clk_i);
      check_out();
    end
  endtask

  task automatic idle();
    @(posedge clk_i);
    valid_i <= 1'b0;
    @(negedge clk_i);
    check_out();
  endtask

  task automatic report_result(string name, int err0);
    $display("test %s %s, %0d errors", name, (n_err == err0) ? "ok" : "failed", n_err - err0);
  endtask

  task automatic reset_test();
    int err0;
    err0 = n_err;
    rst_n_i <= 1'b0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_out();                                      // model is all zero here
    compare("trap_o", 32'(trap_o), 32'h0);
    report_result("reset", err0);
  endtask

  task automatic alu_test();
    int          err0;
    logic [31:0] r;
    err0 = n_err;
    issue(EXC_OPREG, ALU_SRA, BR_EQ, 32'h100, 32'h8000_0f00, 32'd4, 32'h0, 1'b0);
    issue(EXC_OPIMM, ALU_SRA, BR_EQ, 32'h104, 32'hffff_ff80, 32'h0, 32'd3, 1'b0);
    issue(EXC_OPREG, ALU_SLT, BR_EQ, 32'h108, 32'hffff_ffff, 32'd1, 32'h0, 1'b0);
    issue(EXC_OPREG, ALU_SLTU, BR_EQ, 32'h10c, 32'hffff_ffff, 32'd1, 32'h0, 1'b0);
    repeat (36) begin
      r = rnd();
      issue(r[31] ? EXC_OPREG : EXC_OPIMM, alu_op_e'(4'(pick(10))), BR_EQ,
            rnd() & 32'hffff_fffc, rnd(), rnd(), {{20{r[11]}}, r[11:0]}, 1'b0);
    end
    idle();
    report_result("alu", err0);
  endtask

  task automatic addr_test();
    int err0;
    err0 = n_err;
    issue(EXC_LUI, ALU_ADD, BR_EQ, 32'h200, 32'h5, 32'h0, 32'h1234_5abc, 1'b0);
    issue(EXC_AUIPC, ALU_ADD, BR_EQ, 32'h1000, 32'h0, 32'h0, 32'hffff_f123, 1'b0);
    issue(EXC_LOAD, ALU_SUB, BR_EQ, 32'h204, 32'h2000, 32'h0, 32'hffff_fffc, 1'b0);
    issue(EXC_STORE, ALU_XOR, BR_EQ, 32'h208, 32'h3000, 32'h77, 32'h7f8, 1'b1);
    issue(EXC_JAL, ALU_ADD, BR_EQ, 32'h400, 32'h0, 32'h0, 32'h80, 1'b1);
    issue(EXC_JAL, ALU_ADD, BR_EQ, 32'h480, 32'h0, 32'h0, 32'hffff_ff00, 1'b0);
    issue(EXC_JALR, ALU_ADD, BR_EQ, 32'h500, 32'h1001, 32'h0, 32'h20, 1'b0);  // odd sum
    issue(EXC_JALR, ALU_ADD, BR_EQ, 32'h504, 32'h2003, 32'h0, 32'hffff_fffe, 1'b1);
    idle();
    report_result("addr", err0);
  endtask

  task automatic branch_test();
    int          err0;
    int          k;
    br_cond_e    bc;
    logic [31:0] ca [3];
    logic [31:0] cb [3];
    err0 = n_err;
    ca   = '{32'd5, 32'hffff_fff0, 32'h10};
    cb   = '{32'd5, 32'h10, 32'hffff_fff0};
    for (int c = 0; c < 6; c++) begin
      bc = br_cond_e'(3'(c));
      for (int want = 0; want < 2; want++) begin
        k = 0;
        while (k < 2 && taken_ref(EXC_BRANCH, bc, ca[k], cb[k]) != want[0]) k++;
        for (int pt = 0; pt < 2; pt++) begin
          issue(EXC_BRANCH, ALU_ADD, bc, 32'h800 + 32'(c * 16), ca[k], cb[k],
                pt[0] ? 32'hffff_ffc0 : 32'h40, pt[0]);
        end
      end
    end
    idle();
    report_result("branch", err0);
  endtask

  task automatic stall_test();
    int err0;
    err0 = n_err;
    issue(EXC_OPREG, ALU_SUB, BR_EQ, 32'hc00, rnd(), rnd(), 32'h0, 1'b0);
    issue(EXC_BRANCH, ALU_ADD, BR_NE, 32'hc04, 32'h1, 32'h2, 32'h10, 1'b0);
    issue(EXC_JAL, ALU_ADD, BR_EQ, 32'hc08, 32'h0, 32'h0, 32'h100, 1'b1, 3);
    issue(EXC_OPIMM, ALU_OR, BR_EQ, 32'hd08, rnd(), 32'h0, 32'h0f0, 1'b0);
    issue(EXC_JALR, ALU_ADD, BR_EQ, 32'hd0c, 32'h4000, 32'h0, 32'h8, 1'b1);
    issue(EXC_BRANCH, ALU_ADD, BR_GEU, 32'hd10, 32'h9, 32'h9, 32'hffff_fff0, 1'b1);
    idle();
    report_result("stall", err0);
  endtask

  task automatic mix_test();
    int          err0;
    logic [31:0] r;
    exc_op_e     mix [5];
    err0 = n_err;
    mix  = '{EXC_OPREG, EXC_JAL, EXC_JALR, EXC_BRANCH, EXC_LOAD};
    repeat (30) begin
      r = rnd();
      issue(mix[pick(5)], alu_op_e'(4'(pick(10))), br_cond_e'(3'(pick(6))),
            rnd() & 32'hffff_fffc, rnd(), rnd(), {{19{r[12]}}, r[12:1], 1'b0}, r[31]);
    end
    idle();
    compare("cnt_total_o", 32'(cnt_total_o), 32'(e_tot));
    compare("cnt_correct_o", 32'(cnt_correct_o), 32'(e_cor));
    report_result("mix", err0);
  endtask

  initial begin
    rst_n_i      <= 1'b0;
    stall_i      <= 1'b0;
    valid_i      <= 1'b0;
    pc_i         <= '0;
    rs1_i        <= '0;
    rs2_i        <= '0;
    imm_i        <= '0;
    rd_i         <= '0;
    exc_op_i     <= EXC_NONE;
    alu_op_i     <= ALU_ADD;
    br_cond_i    <= BR_EQ;
    pred_taken_i <= 1'b0;
    which_pdt_i  <= 1'b0;
    history_i    <= '0;
    trap_i       <= '0;
    reset_test();
    alu_test();
    addr_test();
    branch_test();
    stall_test();
    mix_test();
    $display("checks %0d, errors %0d", n_chk, n_err);
    if (n_err == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // one cycle per instruction plus slack for reset, idles and stalls
  initial begin
    #((N_ISSUE + 50) * CLK_NS);
    $display("timeout, tests still running after %0d cycles", N_ISSUE + 50);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* src.f */
+incdir+verilog
verilog/exu_isa_pkg.sv
verilog/bpu_pkg.sv
verilog/exu_if.sv
verilog/alu_core.sv
verilog/branch_resolver.sv
verilog/exu_retire.sv
verilog/exu_top.sv
testbench/tb_clk_gen.sv
testbench/tb_exu.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_exu
FILELIST  = src.f
OBJ_DIR   = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)
